// File: sim/pipe5_testdata.txt
# I <address> <word>           program word at a byte address, hex
# E <test> <reg> <value>       expected register write in program order, reg decimal, value hex
I 00000100 80000501
I 00000104 80FFFD02
I 00000108 00800312
I 0000010C 00A00412
I 00000110 00240521
I 00000114 00280612
I 00000118 00200711
I 0000011C 002C0812
I 00000120 00900912
I 00000124 00940A12
I 00000128 00980B12
I 0000012C 00B00C12
I 00000130 00B40D12
I 00000134 00B80E12
I 00000138 00C00F21
I 0000013C 00C40314
I 00000140 80002304
I 00000144 00C40514
I 00000148 900F0FA6
I 0000014C 94800017
I 00000150 9800FF78
I 00000154 80004009
I 00000158 68000498
I 0000015C 4800049A
I 00000160 68000891
I 00000164 4800089B
I 00000168 20000211
I 0000016C 80007A0C
I 00000170 80007B0D
I 00000174 2C000211
I 00000178 8000110C
I 0000017C 8000120D
I 00000180 24000221
I 00000184 80007C0C
I 00000188 80007D0D
I 0000018C 28000212
I 00000190 800001CC
I 00000194 28000211
I 00000198 80007E0D
I 0000019C 80007F0E
I 000001A0 20000212
I 000001A4 800001DD
I 000001A8 80020009
I 000001AC 3000109E
I 000001B0 80007F0F
I 000001B4 80007E0F
I 00000240 800004EF
I 00000244 008001FC
E start_pc_addi 1 00000005
E addi_negative 2 FFFFFFFD
E add_dependent 3 00000002
E sub 4 00000008
E lt_signed 5 00000001
E le_false 6 00000000
E eq_true 7 00000001
E ne_true 8 00000001
E and 9 00000005
E or 10 FFFFFFFD
E xor 11 FFFFFFF8
E nand 12 FFFFFFFA
E nor 13 00000002
E nxor 14 00000007
E rshf_signed 15 FFFFFFFF
E lshf 3 00000500
E addi_shamt 4 00000023
E lshf_low5 5 00000028
E andi 6 00000F0D
E ori_sext 7 FFFF8005
E xori_dependent 8 FFFF80FA
E addi_base 9 00000040
E lw_after_sw 10 FFFF80FA
E lw_after_sw2 11 00000005
E bne_fall_1 12 00000011
E bne_fall_2 13 00000012
E ble_fall 12 00000012
E beq_fall 13 00000013
E addi_jal_base 9 00000200
E jal_link 14 000001B0
E jal_target 15 000001B4
E add_after_jal 1 000001C6

// File: pipe5_cpu.f
common/pipe5_pkg.sv
fetch/fetch_unit.sv
decode/register_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
source/memory_writeback.sv
source/pipe5_cpu.sv
sim/pipe5_checker.sv
sim/pipe5_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the pipe5_cpu testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

build_dir=build
log_file="$build_dir/sim.log"

mkdir -p "$build_dir"
verilator --binary --timing --assert -j 0 \
  --top-module pipe5_tb -Mdir "$build_dir" -o pipe5_sim \
  -f pipe5_cpu.f

"./$build_dir/pipe5_sim" | tee "$log_file"

if grep -qx "Result: PASSED" "$log_file"; then
  echo "Simulation passed"
else
  echo "Simulation failed, see $log_file"
  exit 1
fi

// File: sim/pipe5_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipe5_tb;

  localparam int          imem_words  = 1024;
  localparam int          max_cycles  = 3000;
  localparam int          idle_cycles = 20;
  localparam int          end_wait    = 10;
  localparam logic [31:0] noop_word   = 32'hFC00_0000; // Opcode 111111
  localparam logic [31:0] reset_pc    = 32'h0000_0100; // First fetch after reset
  localparam string       data_path   = "sim/pipe5_testdata.txt";

  logic        clk;
  logic        reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        wb_valid;
  logic [3:0]  wb_regno;
  logic [31:0] wb_data;
  logic        run_end;
  logic        all_seen;
  logic        end_done;
  int          mismatch_count;
  int          extra_count;
  int          missing_count;
  int          file_errors;
  int          other_errors;
  logic [31:0] imem [imem_words];

  pipe5_cpu dut (
    .clk, .reset, .imem_addr, .imem_data, .wb_valid, .wb_regno, .wb_data
  );

  pipe5_checker u_checker (
    .clk, .reset, .wb_valid, .wb_regno, .wb_data, .run_end,
    .all_seen, .end_done, .mismatch_count, .extra_count, .missing_count, .file_errors
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] instruction_at(input logic [31:0] addr);
    if (addr[31:12] != '0) begin
      return noop_word; // Outside the modelled 4 KB
    end
    return imem[addr[11:2]];
  endfunction

  // Data follows the address 1 ns after the rising edge
  always @(posedge clk) begin
    #1;
    imem_data <= instruction_at(imem_addr);
  end

  task automatic load_program();
    int          fd;
    int          loaded;
    string       line;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] rnd;
    loaded = 0;
    for (int i = 0; i < imem_words; i++) begin
      rnd     = $urandom;
      imem[i] = {6'b111111, rnd[25:0]}; // Random no-op filler
    end
    fd = $fopen(data_path, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open %s to read the program words", data_path);
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if ($sscanf(line, "I %h %h", addr, word) == 2) begin
        if (addr[1:0] != 2'b00 || addr[31:12] != '0) begin
          $display("ERROR: program address %h is outside the instruction memory", addr);
          other_errors++;
        end else begin
          imem[addr[11:2]] = word;
          loaded++;
        end
      end
    end
    $fclose(fd);
    if (loaded == 0) begin
      $display("ERROR: no program words found in %s", data_path);
      other_errors++;
    end
  endtask

  initial begin : run_control
    int cycles;
    clk          = 1'b0;
    reset        = 1'b1;
    imem_data    = noop_word;
    run_end      = 1'b0;
    other_errors = 0;
    void'($urandom(28));
    load_program();

    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
    end
    #1 reset = 1'b0;

    if (imem_addr !== reset_pc) begin
      $display("MISMATCH start_pc: expected imem_addr %h, actual %h", reset_pc, imem_addr);
      other_errors++;
    end

    cycles = 0;
    while (!all_seen && cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!all_seen) begin
      $display("ERROR: timed out after %0d cycles waiting for the expected register writes",
               max_cycles);
      other_errors++;
    end else begin
      // Late writes show up as extras
      for (int i = 0; i < idle_cycles; i++) begin
        @(posedge clk);
      end
    end

    #1 run_end = 1'b1;
    cycles = 0;
    while (!end_done && cycles < end_wait) begin
      @(posedge clk);
      cycles++;
    end
    if (!end_done) begin
      $display("ERROR: the checker never finished its end of run check");
      other_errors++;
    end

    $display("Error counts: mismatch %0d, extra %0d, missing %0d, file %0d, other %0d",
             mismatch_count, extra_count, missing_count, file_errors, other_errors);
    if (mismatch_count + extra_count + missing_count + file_errors + other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/pipe5_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pipe5_checker (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_valid,
  input  logic [3:0]  wb_regno,
  input  logic [31:0] wb_data,
  input  logic        run_end,
  output logic        all_seen,
  output logic        end_done,
  output int          mismatch_count,
  output int          extra_count,
  output int          missing_count,
  output int          file_errors
);

  localparam string data_path = "sim/pipe5_testdata.txt";

  // Expected writes, in program order
  string       names  [$];
  logic [3:0]  regnos [$];
  logic [31:0] values [$];

  int   entry_count = 0;
  int   next_entry  = 0;
  logic loaded      = 1'b0;
  int   mismatches  = 0;
  int   extras      = 0;
  int   missing     = 0;
  int   load_errors = 0;
  logic end_checked = 1'b0;

  assign all_seen       = loaded && (next_entry == entry_count);
  assign end_done       = end_checked;
  assign mismatch_count = mismatches;
  assign extra_count    = extras;
  assign missing_count  = missing;
  assign file_errors    = load_errors;

  initial begin : load_expected
    int          fd;
    string       line;
    string       name;
    int          regno;
    logic [31:0] value;
    fd = $fopen(data_path, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open %s to read the expected writes", data_path);
      load_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if ($sscanf(line, "E %s %d %h", name, regno, value) == 3) begin
          if (regno < 0 || regno > 15) begin
            $display("ERROR: test %s names register %0d, which does not exist", name, regno);
            load_errors++;
          end else begin
            names.push_back(name);
            regnos.push_back(regno[3:0]);
            values.push_back(value);
          end
        end
      end
      $fclose(fd);
      entry_count = names.size();
      if (entry_count == 0) begin
        $display("ERROR: no expected register writes found in %s", data_path);
        load_errors++;
      end else begin
        loaded = 1'b1;
      end
    end
  end

  // Sampled on the falling edge, away from the DUT's updates
  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      if (!loaded || next_entry >= entry_count) begin
        extras++;
        $display("ERROR: unexpected register write r%0d = %h after the last expected write",
                 wb_regno, wb_data);
      end else begin
        if (wb_regno != regnos[next_entry] || wb_data != values[next_entry]) begin
          mismatches++;
          $display("MISMATCH %s: expected r%0d = %h, actual r%0d = %h", names[next_entry],
                   regnos[next_entry], values[next_entry], wb_regno, wb_data);
        end
        next_entry++;
      end
    end
    if (run_end && !end_checked) begin
      if (next_entry < entry_count) begin
        missing = entry_count - next_entry;
        $display("ERROR: %0d expected register writes never happened, the first is %s",
                 missing, names[next_entry]);
      end
      end_checked = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/pipe5_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module pipe5_cpu (
  input  logic                                   clk,
  input  logic                                   reset,
  output logic [pipe5_pkg::data_width-1:0]       imem_addr,
  input  logic [pipe5_pkg::data_width-1:0]       imem_data,
  output logic                                   wb_valid,
  output logic [pipe5_pkg::reg_index_width-1:0]  wb_regno,
  output logic [pipe5_pkg::data_width-1:0]       wb_data
);

  // Fetch to decode
  logic [pipe5_pkg::data_width-1:0] inst_fe;
  logic [pipe5_pkg::data_width-1:0] pc_fe;
  logic                             valid_fe;
  logic                             stall;

  // Register file read port
  logic [pipe5_pkg::reg_index_width-1:0] rs_index;
  logic [pipe5_pkg::reg_index_width-1:0] rt_index;
  logic [pipe5_pkg::data_width-1:0]      rs_value;
  logic [pipe5_pkg::data_width-1:0]      rt_value;

  // Decode to execute
  logic [pipe5_pkg::data_width-1:0]      id_pc;
  logic [pipe5_pkg::op1_width-1:0]       id_op1;
  logic [pipe5_pkg::op2_width-1:0]       id_op2;
  logic [pipe5_pkg::data_width-1:0]      id_rs_val;
  logic [pipe5_pkg::data_width-1:0]      id_rt_val;
  logic [pipe5_pkg::data_width-1:0]      id_sxt_imm;
  logic [pipe5_pkg::reg_index_width-1:0] id_dst;
  logic [1:0]                            id_alu_src;
  logic                                  id_mem_we;
  logic                                  id_mem_re;
  logic                                  id_reg_we;
  logic [1:0]                            id_wr_src;
  logic                                  id_branch;
  logic                                  id_jal;

  // Execute to memory, plus the redirect back to fetch
  logic                                  redirect;
  logic [pipe5_pkg::data_width-1:0]      redirect_pc;
  logic [pipe5_pkg::reg_index_width-1:0] ex_dst;
  logic                                  ex_we;
  logic [pipe5_pkg::data_width-1:0]      ex_alu;
  logic [pipe5_pkg::data_width-1:0]      ex_store;
  logic [pipe5_pkg::data_width-1:0]      ex_pc;
  logic                                  ex_mem_we;
  logic                                  ex_mem_re;
  logic [1:0]                            ex_wr_src;

  logic [pipe5_pkg::reg_index_width-1:0] mem_dst;
  logic                                  mem_we;

  fetch_unit u_fetch (
    .clk, .reset, .stall, .redirect, .redirect_pc,
    .imem_addr, .imem_data, .inst_fe, .pc_fe, .valid_fe
  );

  decode_stage u_decode (
    .clk, .reset, .inst_fe, .pc_fe, .valid_fe, .redirect,
    .ex_dst, .ex_we, .mem_dst, .mem_we,
    .rs_index, .rt_index, .rs_value, .rt_value, .stall,
    .id_pc, .id_op1, .id_op2, .id_rs_val, .id_rt_val, .id_sxt_imm, .id_dst,
    .id_alu_src, .id_mem_we, .id_mem_re, .id_reg_we, .id_wr_src, .id_branch, .id_jal
  );

  register_file u_regs (
    .clk, .reset, .rs_index, .rt_index, .rs_value, .rt_value,
    .wr_en(wb_valid), .wr_index(wb_regno), .wr_data(wb_data)
  );

  execute_stage u_execute (
    .clk, .reset,
    .id_pc, .id_op1, .id_op2, .id_rs_val, .id_rt_val, .id_sxt_imm, .id_dst,
    .id_alu_src, .id_mem_we, .id_mem_re, .id_reg_we, .id_wr_src, .id_branch, .id_jal,
    .redirect, .redirect_pc, .ex_dst, .ex_we,
    .ex_alu, .ex_store, .ex_pc, .ex_mem_we, .ex_mem_re, .ex_wr_src
  );

  memory_writeback u_memwb (
    .clk, .reset, .ex_dst, .ex_we, .ex_alu, .ex_store, .ex_pc,
    .ex_mem_we, .ex_mem_re, .ex_wr_src,
    .mem_dst, .mem_we, .wb_valid, .wb_regno, .wb_data
  );

endmodule

`default_nettype wire

// File: source/memory_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module memory_writeback (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [pipe5_pkg::reg_index_width-1:0] ex_dst,
  input  logic                                  ex_we,
  input  logic [pipe5_pkg::data_width-1:0]      ex_alu,
  input  logic [pipe5_pkg::data_width-1:0]      ex_store,
  input  logic [pipe5_pkg::data_width-1:0]      ex_pc,
  input  logic                                  ex_mem_we,
  input  logic                                  ex_mem_re,
  input  logic [1:0]                            ex_wr_src,
  output logic [pipe5_pkg::reg_index_width-1:0] mem_dst,
  output logic                                  mem_we,
  output logic                                  wb_valid,
  output logic [pipe5_pkg::reg_index_width-1:0] wb_regno,
  output logic [pipe5_pkg::data_width-1:0]      wb_data
);

  logic [pipe5_pkg::data_width-1:0]       dmem [pipe5_pkg::dmem_words];
  logic [pipe5_pkg::dmem_index_width-1:0] word_index;
  logic [pipe5_pkg::data_width-1:0]       mem_alu;
  logic [pipe5_pkg::data_width-1:0]       mem_load;
  logic [pipe5_pkg::data_width-1:0]       mem_link;
  logic [1:0]                             mem_wr_src;

  assign word_index = ex_alu[pipe5_pkg::dmem_index_width+1:2];

  always_ff @(posedge clk) begin
    if (ex_mem_we) begin
      dmem[word_index] <= ex_store;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mem_we     <= 1'b0;
      mem_wr_src <= pipe5_pkg::wr_src_alu;
    end else begin
      mem_we     <= ex_we;
      mem_wr_src <= ex_wr_src;
    end
  end

  always_ff @(posedge clk) begin
    mem_dst  <= ex_dst;
    mem_alu  <= ex_alu;
    mem_load <= ex_mem_re ? dmem[word_index] : '0; // Read only for LW
    mem_link <= ex_pc;
  end

  always_comb begin
    case (mem_wr_src)
      pipe5_pkg::wr_src_pc:  wb_data = mem_link;
      pipe5_pkg::wr_src_mem: wb_data = mem_load;
      pipe5_pkg::wr_src_alu: wb_data = mem_alu;
      default:               wb_data = '0;
    endcase
  end

  // One strobe per register write, shared with the register file
  assign wb_valid = mem_we;
  assign wb_regno = mem_dst;

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [pipe5_pkg::data_width-1:0]      id_pc,
  input  logic [pipe5_pkg::op1_width-1:0]       id_op1,
  input  logic [pipe5_pkg::op2_width-1:0]       id_op2,
  input  logic [pipe5_pkg::data_width-1:0]      id_rs_val,
  input  logic [pipe5_pkg::data_width-1:0]      id_rt_val,
  input  logic [pipe5_pkg::data_width-1:0]      id_sxt_imm,
  input  logic [pipe5_pkg::reg_index_width-1:0] id_dst,
  input  logic [1:0]                            id_alu_src,
  input  logic                                  id_mem_we,
  input  logic                                  id_mem_re,
  input  logic                                  id_reg_we,
  input  logic [1:0]                            id_wr_src,
  input  logic                                  id_branch,
  input  logic                                  id_jal,
  output logic                                  redirect,
  output logic [pipe5_pkg::data_width-1:0]      redirect_pc,
  output logic [pipe5_pkg::reg_index_width-1:0] ex_dst,
  output logic                                  ex_we,
  output logic [pipe5_pkg::data_width-1:0]      ex_alu,
  output logic [pipe5_pkg::data_width-1:0]      ex_store,
  output logic [pipe5_pkg::data_width-1:0]      ex_pc,
  output logic                                  ex_mem_we,
  output logic                                  ex_mem_re,
  output logic [1:0]                            ex_wr_src
);

  logic [pipe5_pkg::data_width-1:0] imm4;
  logic [pipe5_pkg::data_width-1:0] alu_b;
  logic [pipe5_pkg::data_width-1:0] alu_out;
  logic [pipe5_pkg::data_width-1:0] pc_next;
  logic                             eq;
  logic                             lt;

  function automatic logic [pipe5_pkg::data_width-1:0] flag(input logic cond);
    flag    = '0;
    flag[0] = cond;
  endfunction

  assign imm4    = id_sxt_imm << 2;
  assign pc_next = id_pc + pipe5_pkg::inst_size; // Also the JAL link

  always_comb begin
    case (id_alu_src)
      pipe5_pkg::alu_src_imm:  alu_b = id_sxt_imm;
      pipe5_pkg::alu_src_imm4: alu_b = imm4;
      default:                 alu_b = id_rt_val;
    endcase
  end

  assign eq = id_rs_val == alu_b;
  assign lt = $signed(id_rs_val) < $signed(alu_b); // Signed compare

  always_comb begin
    case (id_op1)
      pipe5_pkg::op1_alur: begin
        case (id_op2)
          pipe5_pkg::op2_eq:   alu_out = flag(eq);
          pipe5_pkg::op2_lt:   alu_out = flag(lt);
          pipe5_pkg::op2_le:   alu_out = flag(lt || eq);
          pipe5_pkg::op2_ne:   alu_out = flag(!eq);
          pipe5_pkg::op2_add:  alu_out = id_rs_val + alu_b;
          pipe5_pkg::op2_and:  alu_out = id_rs_val & alu_b;
          pipe5_pkg::op2_or:   alu_out = id_rs_val | alu_b;
          pipe5_pkg::op2_xor:  alu_out = id_rs_val ^ alu_b;
          pipe5_pkg::op2_sub:  alu_out = id_rs_val - alu_b;
          pipe5_pkg::op2_nand: alu_out = ~(id_rs_val & alu_b);
          pipe5_pkg::op2_nor:  alu_out = ~(id_rs_val | alu_b);
          pipe5_pkg::op2_nxor: alu_out = ~(id_rs_val ^ alu_b);
          pipe5_pkg::op2_rshf: alu_out = $signed(id_rs_val) >>> alu_b[4:0];
          pipe5_pkg::op2_lshf: alu_out = id_rs_val << alu_b[4:0];
          default:             alu_out = '0;
        endcase
      end
      pipe5_pkg::op1_beq:  alu_out = flag(eq);
      pipe5_pkg::op1_blt:  alu_out = flag(lt);
      pipe5_pkg::op1_ble:  alu_out = flag(lt || eq);
      pipe5_pkg::op1_bne:  alu_out = flag(!eq);
      pipe5_pkg::op1_jal, pipe5_pkg::op1_lw, pipe5_pkg::op1_sw, pipe5_pkg::op1_addi:
        alu_out = id_rs_val + alu_b; // Jump target or address
      pipe5_pkg::op1_andi: alu_out = id_rs_val & alu_b;
      pipe5_pkg::op1_ori:  alu_out = id_rs_val | alu_b;
      pipe5_pkg::op1_xori: alu_out = id_rs_val ^ alu_b;
      default:             alu_out = '0;
    endcase
  end

  // Branches resolve here, two younger slots get flushed
  assign redirect    = id_jal || (id_branch && alu_out[0]);
  assign redirect_pc = id_jal ? alu_out : pc_next + imm4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_we     <= 1'b0;
      ex_mem_we <= 1'b0;
      ex_mem_re <= 1'b0;
      ex_wr_src <= pipe5_pkg::wr_src_alu;
    end else begin
      ex_we     <= id_reg_we;
      ex_mem_we <= id_mem_we;
      ex_mem_re <= id_mem_re;
      ex_wr_src <= id_wr_src;
    end
  end

  always_ff @(posedge clk) begin
    ex_dst   <= id_dst;
    ex_alu   <= alu_out;
    ex_store <= id_rt_val;
    ex_pc    <= pc_next;
  end

  // Decode bubbles the slot behind a redirect
  one_redirect: assert property (@(posedge clk) disable iff (reset) redirect |=> !redirect)
    else $error("redirect raised by a flushed instruction");

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [pipe5_pkg::data_width-1:0]      inst_fe,
  input  logic [pipe5_pkg::data_width-1:0]      pc_fe,
  input  logic                                  valid_fe,
  input  logic                                  redirect,
  input  logic [pipe5_pkg::reg_index_width-1:0] ex_dst,
  input  logic                                  ex_we,
  input  logic [pipe5_pkg::reg_index_width-1:0] mem_dst,
  input  logic                                  mem_we,
  output logic [pipe5_pkg::reg_index_width-1:0] rs_index,
  output logic [pipe5_pkg::reg_index_width-1:0] rt_index,
  input  logic [pipe5_pkg::data_width-1:0]      rs_value,
  input  logic [pipe5_pkg::data_width-1:0]      rt_value,
  output logic                                  stall,
  output logic [pipe5_pkg::data_width-1:0]      id_pc,
  output logic [pipe5_pkg::op1_width-1:0]       id_op1,
  output logic [pipe5_pkg::op2_width-1:0]       id_op2,
  output logic [pipe5_pkg::data_width-1:0]      id_rs_val,
  output logic [pipe5_pkg::data_width-1:0]      id_rt_val,
  output logic [pipe5_pkg::data_width-1:0]      id_sxt_imm,
  output logic [pipe5_pkg::reg_index_width-1:0] id_dst,
  output logic [1:0]                            id_alu_src,
  output logic                                  id_mem_we,
  output logic                                  id_mem_re,
  output logic                                  id_reg_we,
  output logic [1:0]                            id_wr_src,
  output logic                                  id_branch,
  output logic                                  id_jal
);

  pipe5_pkg::instr_t inst;

  logic [1:0] alu_src;
  logic [1:0] wr_src;
  logic       mem_we_c;
  logic       mem_re_c;
  logic       reg_we_c;
  logic       branch;
  logic       jal;
  logic       dst_rd;
  logic       use_rs;
  logic       use_rt;
  logic       rs_busy;
  logic       rt_busy;
  logic       bubble;

  assign inst     = inst_fe;
  assign rs_index = inst.alur.rs;
  assign rt_index = inst.alur.rt;

  // Bubbles and unknown opcodes get no-op controls
  always_comb begin
    alu_src  = pipe5_pkg::alu_src_rt;
    wr_src   = pipe5_pkg::wr_src_alu;
    mem_we_c = 1'b0;
    mem_re_c = 1'b0;
    reg_we_c = 1'b0;
    branch   = 1'b0;
    jal      = 1'b0;
    dst_rd   = 1'b0;
    use_rs   = 1'b0;
    use_rt   = 1'b0;
    if (valid_fe) begin
      case (inst.alur.op1)
        pipe5_pkg::op1_alur: begin
          reg_we_c = 1'b1;
          dst_rd   = 1'b1;
          use_rs   = 1'b1;
          use_rt   = 1'b1;
        end
        pipe5_pkg::op1_beq, pipe5_pkg::op1_blt, pipe5_pkg::op1_ble, pipe5_pkg::op1_bne: begin
          branch = 1'b1; // Compares rs with rt
          use_rs = 1'b1;
          use_rt = 1'b1;
        end
        pipe5_pkg::op1_jal: begin
          alu_src  = pipe5_pkg::alu_src_imm4;
          wr_src   = pipe5_pkg::wr_src_pc;
          reg_we_c = 1'b1;
          jal      = 1'b1;
          use_rs   = 1'b1;
        end
        pipe5_pkg::op1_lw: begin
          alu_src  = pipe5_pkg::alu_src_imm;
          wr_src   = pipe5_pkg::wr_src_mem;
          mem_re_c = 1'b1;
          reg_we_c = 1'b1;
          use_rs   = 1'b1;
        end
        pipe5_pkg::op1_sw: begin
          alu_src  = pipe5_pkg::alu_src_imm;
          mem_we_c = 1'b1;
          use_rs   = 1'b1;
          use_rt   = 1'b1; // Store data
        end
        pipe5_pkg::op1_addi, pipe5_pkg::op1_andi, pipe5_pkg::op1_ori, pipe5_pkg::op1_xori: begin
          alu_src  = pipe5_pkg::alu_src_imm;
          reg_we_c = 1'b1;
          use_rs   = 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Any older writer still in execute, memory or writeback
  assign rs_busy = (id_reg_we && id_dst == rs_index) || (ex_we && ex_dst == rs_index) ||
                   (mem_we && mem_dst == rs_index);
  assign rt_busy = (id_reg_we && id_dst == rt_index) || (ex_we && ex_dst == rt_index) ||
                   (mem_we && mem_dst == rt_index);

  assign stall  = (use_rs && rs_busy) || (use_rt && rt_busy);
  assign bubble = stall || redirect;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_mem_we  <= 1'b0;
      id_mem_re  <= 1'b0;
      id_reg_we  <= 1'b0;
      id_branch  <= 1'b0;
      id_jal     <= 1'b0;
      id_alu_src <= pipe5_pkg::alu_src_rt;
      id_wr_src  <= pipe5_pkg::wr_src_alu;
    end else begin
      id_mem_we  <= mem_we_c && !bubble;
      id_mem_re  <= mem_re_c && !bubble;
      id_reg_we  <= reg_we_c && !bubble;
      id_branch  <= branch && !bubble;
      id_jal     <= jal && !bubble;
      id_alu_src <= alu_src;
      id_wr_src  <= wr_src;
    end
  end

  always_ff @(posedge clk) begin
    id_pc      <= pc_fe;
    id_op1     <= inst.alur.op1;
    id_op2     <= inst.alur.op2;
    id_rs_val  <= rs_value;
    id_rt_val  <= rt_value;
    id_sxt_imm <= {{(pipe5_pkg::data_width - pipe5_pkg::imm_width){inst.imm.imm[15]}},
                   inst.imm.imm};
    id_dst     <= dst_rd ? inst.alur.rd : inst.alur.rt;
  end

  // Fetch must hold the stalled word for the retry
  stall_holds_fetch: assert property (@(posedge clk) disable iff (reset)
    (stall && !redirect) |=> (valid_fe && $stable(inst_fe)))
    else $error("fetch register changed while decode was stalled");

endmodule

`default_nettype wire

// File: decode/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [pipe5_pkg::reg_index_width-1:0] rs_index,
  input  logic [pipe5_pkg::reg_index_width-1:0] rt_index,
  output logic [pipe5_pkg::data_width-1:0]      rs_value,
  output logic [pipe5_pkg::data_width-1:0]      rt_value,
  input  logic                                  wr_en,
  input  logic [pipe5_pkg::reg_index_width-1:0] wr_index,
  input  logic [pipe5_pkg::data_width-1:0]      wr_data
);

  logic [pipe5_pkg::data_width-1:0] regs [2**pipe5_pkg::reg_index_width];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**pipe5_pkg::reg_index_width; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_index] <= wr_data;
    end
  end

  // Write-through, decode sees this cycle's writeback
  assign rs_value = (wr_en && wr_index == rs_index) ? wr_data : regs[rs_index];
  assign rt_value = (wr_en && wr_index == rt_index) ? wr_data : regs[rt_index];

endmodule

`default_nettype wire

// File: fetch/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             stall,
  input  logic                             redirect,
  input  logic [pipe5_pkg::data_width-1:0] redirect_pc,
  output logic [pipe5_pkg::data_width-1:0] imem_addr,
  input  logic [pipe5_pkg::data_width-1:0] imem_data,
  output logic [pipe5_pkg::data_width-1:0] inst_fe,
  output logic [pipe5_pkg::data_width-1:0] pc_fe,
  output logic                             valid_fe
);

  logic [pipe5_pkg::data_width-1:0] pc;

  assign imem_addr = pc; // Memory answers in the same cycle

  // Redirect beats stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc       <= pipe5_pkg::start_pc;
      valid_fe <= 1'b0;
    end else if (redirect) begin
      pc       <= redirect_pc;
      valid_fe <= 1'b0; // Word in flight is the wrong path
    end else if (!stall) begin
      pc       <= pc + pipe5_pkg::inst_size;
      valid_fe <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      inst_fe <= imem_data;
      pc_fe   <= pc;
    end
  end

  // Catches a JAL through a register that is not word aligned
  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("fetch PC %h is not word aligned", pc);

endmodule

`default_nettype wire

// File: common/pipe5_pkg.sv
`default_nettype none

package pipe5_pkg;

  localparam int data_width      = 32;
  localparam int reg_index_width = 4;
  localparam int op1_width       = 6;
  localparam int op2_width       = 8;
  localparam int imm_width       = 16;

  localparam logic [data_width-1:0] start_pc  = 32'h100;
  localparam logic [data_width-1:0] inst_size = 32'd4;

  localparam int dmem_words       = 1024;
  localparam int dmem_index_width = $clog2(dmem_words); // Taken from address bits 11:2

  // Primary opcodes
  localparam logic [op1_width-1:0] op1_alur = 6'b000000;
  localparam logic [op1_width-1:0] op1_beq  = 6'b001000;
  localparam logic [op1_width-1:0] op1_blt  = 6'b001001;
  localparam logic [op1_width-1:0] op1_ble  = 6'b001010;
  localparam logic [op1_width-1:0] op1_bne  = 6'b001011;
  localparam logic [op1_width-1:0] op1_jal  = 6'b001100;
  localparam logic [op1_width-1:0] op1_lw   = 6'b010010;
  localparam logic [op1_width-1:0] op1_sw   = 6'b011010;
  localparam logic [op1_width-1:0] op1_addi = 6'b100000;
  localparam logic [op1_width-1:0] op1_andi = 6'b100100;
  localparam logic [op1_width-1:0] op1_ori  = 6'b100101;
  localparam logic [op1_width-1:0] op1_xori = 6'b100110;

  // Secondary opcodes, ALUR only
  localparam logic [op2_width-1:0] op2_eq   = 8'b00001000;
  localparam logic [op2_width-1:0] op2_lt   = 8'b00001001;
  localparam logic [op2_width-1:0] op2_le   = 8'b00001010;
  localparam logic [op2_width-1:0] op2_ne   = 8'b00001011;
  localparam logic [op2_width-1:0] op2_add  = 8'b00100000;
  localparam logic [op2_width-1:0] op2_and  = 8'b00100100;
  localparam logic [op2_width-1:0] op2_or   = 8'b00100101;
  localparam logic [op2_width-1:0] op2_xor  = 8'b00100110;
  localparam logic [op2_width-1:0] op2_sub  = 8'b00101000;
  localparam logic [op2_width-1:0] op2_nand = 8'b00101100;
  localparam logic [op2_width-1:0] op2_nor  = 8'b00101101;
  localparam logic [op2_width-1:0] op2_nxor = 8'b00101110;
  localparam logic [op2_width-1:0] op2_rshf = 8'b00110000;
  localparam logic [op2_width-1:0] op2_lshf = 8'b00110001;

  localparam logic [1:0] alu_src_rt   = 2'b00; // Rt contents
  localparam logic [1:0] alu_src_imm  = 2'b01; // Sign-extended immediate
  localparam logic [1:0] alu_src_imm4 = 2'b10; // Immediate times four

  localparam logic [1:0] wr_src_pc  = 2'b00; // Link PC
  localparam logic [1:0] wr_src_mem = 2'b01;
  localparam logic [1:0] wr_src_alu = 2'b10;

  typedef struct packed {
    logic [op1_width-1:0]       op1;
    logic [op2_width-1:0]       op2;
    logic [5:0]                 spare;
    logic [reg_index_width-1:0] rd;
    logic [reg_index_width-1:0] rs;
    logic [reg_index_width-1:0] rt;
  } inst_alur_t;

  typedef struct packed {
    logic [op1_width-1:0]       op1;
    logic [1:0]                 spare;
    logic [imm_width-1:0]       imm;
    logic [reg_index_width-1:0] rs;
    logic [reg_index_width-1:0] rt;
  } inst_imm_t;

  // Same word, register or immediate view
  typedef union packed {
    inst_alur_t alur;
    inst_imm_t  imm;
  } instr_t;

endpackage

`default_nettype wire
